// ==== include/ad9434_params.svh ====
`ifndef AD9434_PARAMS_SVH
`define AD9434_PARAMS_SVH

// ad9434 runs at 200 MSPS on adc_clk
`define AD_CYCLES_PER_US     200

// packing and block geometry
`define AD_SAMPLES_PER_WORD  4
`define AD_WORDS_PER_BLOCK   32
`define AD_BLOCK_BYTES       256

// word buffer between packer and writer
`define AD_FIFO_DEPTH        64

// write engine command constants
`define AD_DDR_BASE_ADDR     32'h3400_0000
`define AD_WR_EOF_TAG        4'b1010

`endif

// ==== src/ad9434_pkg.sv ====
`default_nettype none

package ad9434_pkg;

  // both halves of one DDR conversion, already registered
  typedef struct packed {
    logic [5:0] rise;  // msbs D11..D6
    logic [5:0] fall;  // lsbs D5..D0
  } adc_ddr_t;

  typedef struct packed {
    logic [3:0] zext;  // always zero
    logic [5:0] rise;
    logic [5:0] fall;
  } sample_t;

  typedef logic [63:0] pack_word_t;  // sample k in bits 16k+15:16k

  // 72-bit s2mm command
  typedef struct packed {
    logic [3:0]  rsvd;
    logic [3:0]  tag;    // echoed back in status
    logic [31:0] saddr;  // destination byte address
    logic        drr;
    logic        eof;
    logic [5:0]  dsa;
    logic        incr;   // incrementing burst
    logic [22:0] btt;    // bytes to transfer
  } s2mm_cmd_t;

  typedef struct packed {
    logic [63:0] tdata;
    logic [7:0]  tkeep;
    logic        tlast;
  } s2mm_data_t;

  typedef struct packed {
    logic [3:0] tdata;
    logic       tkeep;
    logic       tlast;
  } s2mm_sts_t;

endpackage

`default_nettype wire

// ==== src/capture_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ad9434_params.svh"

module capture_ctrl (
  input  wire logic       adc_clk,
  input  wire logic       rst,
  input  wire logic       i_trig,        // async level
  input  wire logic [9:0] i_us_capture,  // length in us
  output logic            o_sample_en,
  output logic            o_start,
  output logic            o_cap_done
);

  typedef enum logic [3:0] {
    ST_IDLE    = 4'b0001,
    ST_CAPTURE = 4'b0010,
    ST_DONE    = 4'b0100,
    ST_END     = 4'b1000
  } cap_state_t;

  localparam int CYC_W = $clog2(`AD_CYCLES_PER_US);

  cap_state_t       state;
  cap_state_t       state_nx;
  logic             trig_meta;          // first sync stage
  logic             trig_sync;          // second sync stage
  logic [9:0]       us_len;             // length latched at trigger
  logic [9:0]       us_cnt;             // whole microseconds elapsed
  logic [CYC_W-1:0] cyc_cnt;            // cycles within current us
  logic             us_wrap;
  logic             last_cyc;

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      trig_meta <= 1'b0;
      trig_sync <= 1'b0;
    end else begin
      trig_meta <= i_trig;
      trig_sync <= trig_meta;
    end
  end

  assign us_wrap  = (cyc_cnt == CYC_W'(`AD_CYCLES_PER_US - 1));
  assign last_cyc = us_wrap && (us_cnt == us_len - 10'd1);  // final sample cycle

  always_comb begin
    state_nx = state;
    case (state)
      ST_IDLE:    if (trig_sync) state_nx = ST_CAPTURE;
      ST_CAPTURE: if (last_cyc) state_nx = ST_DONE;
      ST_DONE:    state_nx = ST_END;
      ST_END:     state_nx = ST_IDLE;   // trigger seen again only from here on
      default:    state_nx = ST_IDLE;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      cyc_cnt    <= '0;
      us_cnt     <= '0;
      o_start    <= 1'b0;
      o_cap_done <= 1'b0;
    end else begin
      state      <= state_nx;
      o_start    <= (state == ST_IDLE) && trig_sync;  // first capture cycle
      o_cap_done <= (state == ST_END);                // 2 cycles after last sample
      if (state == ST_CAPTURE) begin
        if (us_wrap) begin
          cyc_cnt <= '0;
          us_cnt  <= us_cnt + 10'd1;
        end else begin
          cyc_cnt <= cyc_cnt + 1'b1;
        end
      end else begin
        cyc_cnt <= '0;
        us_cnt  <= '0;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if ((state == ST_IDLE) && trig_sync) begin
      us_len <= i_us_capture;  // hold length for the whole capture
    end
  end

  // packer registers i_adc alongside this, so sample 0 lands one edge later
  assign o_sample_en = (state == ST_CAPTURE);

  // a zero length would let the us counter run past the latched length
  a_len_bound: assert property (@(posedge adc_clk) disable iff (rst)
    (state == ST_CAPTURE) |-> (us_cnt < us_len));

endmodule

`default_nettype wire

// ==== src/sample_packer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ad9434_params.svh"

module sample_packer (
  input  wire logic                   adc_clk,
  input  wire logic                   rst,
  input  wire ad9434_pkg::adc_ddr_t   i_adc,
  input  wire logic                   i_sample_en,
  output ad9434_pkg::pack_word_t      o_word,
  output logic                        o_word_wr,
  output logic                        o_block_done
);

  import ad9434_pkg::*;

  localparam int SLOT_W = $clog2(`AD_SAMPLES_PER_WORD);
  localparam int WORD_W = $clog2(`AD_WORDS_PER_BLOCK);
  localparam int SMP_W  = $bits(sample_t);

  adc_ddr_t          adc_r;       // input register
  logic              en_r;        // enable aligned with adc_r
  logic [SLOT_W-1:0] slot;        // sample position in word
  logic [WORD_W-1:0] word_cnt;    // word position in block
  logic              padding;
  logic              take;
  sample_t           cur_sample;
  pack_word_t        shreg;       // upper 3 slots hold earlier samples

  always_ff @(posedge adc_clk) begin
    adc_r <= i_adc;
  end

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      en_r <= 1'b0;
    end else begin
      en_r <= i_sample_en;
    end
  end

  // enable gone but block not complete yet
  assign padding = !en_r && ((slot != '0) || (word_cnt != '0));
  assign take    = en_r || padding;

  always_comb begin
    cur_sample = '0;  // zero sample while padding
    if (en_r) begin
      cur_sample.rise = adc_r.rise;
      cur_sample.fall = adc_r.fall;
    end
  end

  // newest sample enters at the top, oldest ends at bits 15:0
  assign o_word       = {cur_sample, shreg[$bits(pack_word_t)-1:SMP_W]};
  assign o_word_wr    = take && (slot == SLOT_W'(`AD_SAMPLES_PER_WORD - 1));
  assign o_block_done = o_word_wr && (word_cnt == WORD_W'(`AD_WORDS_PER_BLOCK - 1));

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      slot     <= '0;
      word_cnt <= '0;
    end else if (take) begin
      slot <= slot + 1'b1;  // power of two so wraps on its own
      if (o_word_wr) begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (take) begin
      shreg <= o_word;
    end
  end

  // no new capture while the last block is still padded
  a_pad_quiet: assert property (@(posedge adc_clk) disable iff (rst)
    padding |-> !i_sample_en);

endmodule

`default_nettype wire

// ==== src/sample_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ad9434_params.svh"

module sample_fifo (
  input  wire logic                   adc_clk,
  input  wire logic                   rst,
  input  wire logic                   i_wr,
  input  wire ad9434_pkg::pack_word_t i_din,
  input  wire logic                   i_rd,
  output ad9434_pkg::pack_word_t      o_dout,
  output logic                        o_empty,
  output logic                        o_overflow   // sticky until reset
);

  import ad9434_pkg::*;

  localparam int AW = $clog2(`AD_FIFO_DEPTH);

  pack_word_t mem [`AD_FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;   // occupancy 0..depth
  logic          full;
  logic          wr_ok;
  logic          rd_ok;

  assign full    = (count == (AW+1)'(`AD_FIFO_DEPTH));
  assign o_empty = (count == '0);
  assign wr_ok   = i_wr && !full;     // write when full is lost
  assign rd_ok   = i_rd && !o_empty;
  assign o_dout  = mem[rd_ptr];       // fwft head

  always_ff @(posedge adc_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= i_din;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      o_overflow <= 1'b0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (i_wr && full) begin
        o_overflow <= 1'b1;
      end
    end
  end

  // writer must only pop a visible head word
  a_no_underflow: assert property (@(posedge adc_clk) disable iff (rst)
    i_rd |-> !o_empty);

endmodule

`default_nettype wire

// ==== src/s2mm_burst_writer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ad9434_params.svh"

module s2mm_burst_writer (
  input  wire logic                   adc_clk,
  input  wire logic                   rst,
  input  wire logic                   i_start,       // new capture, restart addressing
  input  wire logic                   i_block_done,  // one full block now in fifo
  input  wire ad9434_pkg::pack_word_t i_fifo_word,
  input  wire logic                   i_fifo_empty,
  output logic                        o_fifo_rd,
  output ad9434_pkg::s2mm_cmd_t       o_cmd,
  output logic                        o_cmd_valid,
  input  wire logic                   i_cmd_ready,
  output ad9434_pkg::s2mm_data_t      o_wr,
  output logic                        o_wr_valid,
  input  wire logic                   i_wr_ready,
  input  wire ad9434_pkg::s2mm_sts_t  i_sts,
  input  wire logic                   i_sts_valid
);

  import ad9434_pkg::*;

  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,
    WR_CMD  = 2'd1,
    WR_DATA = 2'd2,
    WR_WAIT = 2'd3
  } wr_state_t;

  localparam int BEAT_W = $clog2(`AD_WORDS_PER_BLOCK);
  localparam int PEND_W = 8;

  wr_state_t         state;
  wr_state_t         state_nx;
  logic [PEND_W-1:0] pending;     // blocks ready but not yet commanded
  logic [BEAT_W-1:0] beat_cnt;    // beats sent in current block
  logic [31:0]       addr;        // saddr of next command
  logic              cmd_go;
  logic              cmd_xfer;
  logic              beat_xfer;
  logic              last_beat;
  logic              sts_ok;

  assign cmd_go    = (state == WR_IDLE) && (pending != '0);
  assign cmd_xfer  = o_cmd_valid && i_cmd_ready;
  assign beat_xfer = o_wr_valid && i_wr_ready;
  assign last_beat = (beat_cnt == BEAT_W'(`AD_WORDS_PER_BLOCK - 1));
  assign sts_ok    = i_sts_valid && i_sts.tkeep && i_sts.tlast &&
                     (i_sts.tdata == `AD_WR_EOF_TAG);  // other status beats dropped

  always_comb begin
    state_nx = state;
    case (state)
      WR_IDLE: if (cmd_go) state_nx = WR_CMD;
      WR_CMD:  if (cmd_xfer) state_nx = WR_DATA;
      WR_DATA: if (beat_xfer && last_beat) state_nx = WR_WAIT;
      WR_WAIT: if (sts_ok) state_nx = WR_IDLE;
      default: state_nx = WR_IDLE;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      state    <= WR_IDLE;
      pending  <= '0;
      beat_cnt <= '0;
      addr     <= `AD_DDR_BASE_ADDR;
    end else begin
      state <= state_nx;
      if (i_start) begin
        pending <= '0;
      end else begin
        pending <= pending + PEND_W'(i_block_done) - PEND_W'(cmd_go);
      end
      if (i_start) begin
        addr <= `AD_DDR_BASE_ADDR;
      end else if (cmd_xfer) begin
        addr <= addr + 32'(`AD_BLOCK_BYTES);  // next 256 B block
      end
      if (state == WR_IDLE) begin
        beat_cnt <= '0;
      end else if (beat_xfer) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    o_cmd       = '0;               // rsvd, drr, dsa stay zero
    o_cmd.tag   = `AD_WR_EOF_TAG;
    o_cmd.saddr = addr;
    o_cmd.eof   = 1'b1;
    o_cmd.incr  = 1'b1;
    o_cmd.btt   = 23'(`AD_BLOCK_BYTES);
  end

  assign o_cmd_valid = (state == WR_CMD);

  // data comes straight from the fwft head, popped only on a transfer
  assign o_wr.tdata = i_fifo_word;
  assign o_wr.tkeep = '1;
  assign o_wr.tlast = last_beat;
  assign o_wr_valid = (state == WR_DATA) && !i_fifo_empty;
  assign o_fifo_rd  = beat_xfer;

  a_wr_hold: assert property (@(posedge adc_clk) disable iff (rst)
    (o_wr_valid && !i_wr_ready) |=> (o_wr_valid && $stable(o_wr)));

endmodule

`default_nettype wire

// ==== src/ad9434_capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ad9434_capture_top (
  input  wire logic                  adc_clk,
  input  wire logic                  rst,
  input  wire logic                  i_trig,
  input  wire logic [9:0]            i_us_capture,
  input  wire ad9434_pkg::adc_ddr_t  i_adc,
  output logic                       o_cap_done,
  output logic                       o_overflow,
  output ad9434_pkg::s2mm_cmd_t      o_cmd,
  output logic                       o_cmd_valid,
  input  wire logic                  i_cmd_ready,
  output ad9434_pkg::s2mm_data_t     o_wr,
  output logic                       o_wr_valid,
  input  wire logic                  i_wr_ready,
  input  wire ad9434_pkg::s2mm_sts_t i_sts,
  input  wire logic                  i_sts_valid
);

  import ad9434_pkg::*;

  logic       sample_en;    // ctrl to packer
  logic       start;        // capture begins
  pack_word_t word;
  logic       word_wr;
  logic       block_done;
  pack_word_t fifo_word;    // fwft head
  logic       fifo_empty;
  logic       fifo_rd;

  capture_ctrl u_ctrl (
    .adc_clk      (adc_clk),
    .rst          (rst),
    .i_trig       (i_trig),
    .i_us_capture (i_us_capture),
    .o_sample_en  (sample_en),
    .o_start      (start),
    .o_cap_done   (o_cap_done)
  );

  sample_packer u_packer (
    .adc_clk      (adc_clk),
    .rst          (rst),
    .i_adc        (i_adc),
    .i_sample_en  (sample_en),
    .o_word       (word),
    .o_word_wr    (word_wr),
    .o_block_done (block_done)
  );

  sample_fifo u_fifo (
    .adc_clk    (adc_clk),
    .rst        (rst),
    .i_wr       (word_wr),
    .i_din      (word),
    .i_rd       (fifo_rd),
    .o_dout     (fifo_word),
    .o_empty    (fifo_empty),
    .o_overflow (o_overflow)
  );

  s2mm_burst_writer u_writer (
    .adc_clk      (adc_clk),
    .rst          (rst),
    .i_start      (start),
    .i_block_done (block_done),
    .i_fifo_word  (fifo_word),
    .i_fifo_empty (fifo_empty),
    .o_fifo_rd    (fifo_rd),
    .o_cmd        (o_cmd),
    .o_cmd_valid  (o_cmd_valid),
    .i_cmd_ready  (i_cmd_ready),
    .o_wr         (o_wr),
    .o_wr_valid   (o_wr_valid),
    .i_wr_ready   (i_wr_ready),
    .i_sts        (i_sts),
    .i_sts_valid  (i_sts_valid)
  );

endmodule

`default_nettype wire

// ==== verification/s2mm_responder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ad9434_params.svh"

module s2mm_responder #(
  parameter logic [31:0] SEED = 32'h1
) (
  input  wire logic                   adc_clk,
  input  wire logic                   rst,
  input  wire ad9434_pkg::s2mm_cmd_t  i_cmd,
  input  wire logic                   i_cmd_valid,
  output logic                        o_cmd_ready,
  input  wire ad9434_pkg::s2mm_data_t i_wr,
  input  wire logic                   i_wr_valid,
  output logic                        o_wr_ready,
  output ad9434_pkg::s2mm_sts_t       o_sts,
  output logic                        o_sts_valid
);

  import ad9434_pkg::*;

  s2mm_cmd_t  cmd_q[$];   // every accepted command, in order
  s2mm_data_t data_q[$];  // every accepted data beat, in order
  integer     seed;
  int         sts_delay;  // cycles left before next status beat
  logic       sts_armed;  // a block ended, status owed
  logic       bad_first;  // send a wrong-tag beat ahead of the real one

  initial begin
    seed        = SEED;
    o_cmd_ready = 1'b0;
    o_wr_ready  = 1'b0;
    o_sts       = '0;
    o_sts_valid = 1'b0;
    sts_delay   = 0;
    sts_armed   = 1'b0;
    bad_first   = 1'b0;
  end

  always @(posedge adc_clk) begin
    if (rst) begin
      o_cmd_ready <= 1'b0;
      o_wr_ready  <= 1'b0;
      o_sts       <= '0;
      o_sts_valid <= 1'b0;
      sts_armed   = 1'b0;
    end else begin
      if (i_cmd_valid && o_cmd_ready) begin
        cmd_q.push_back(i_cmd);
      end
      if (i_wr_valid && o_wr_ready) begin
        data_q.push_back(i_wr);
        if (i_wr.tlast) begin
          sts_armed = 1'b1;
          sts_delay = $random(seed) & 7;              // 0..7 cycles
          bad_first = (($random(seed) & 3) == 0);     // about one block in four
        end
      end
      o_cmd_ready <= (($random(seed) & 3) != 0);      // ~75% ready
      o_wr_ready  <= (($random(seed) & 3) != 0);
      o_sts_valid <= 1'b0;
      o_sts       <= '0;
      if (sts_armed) begin
        if (sts_delay > 0) begin
          sts_delay = sts_delay - 1;
        end else if (bad_first) begin
          o_sts       <= {`AD_WR_EOF_TAG ^ 4'b0110, 1'b1, 1'b1};  // wrong tag
          o_sts_valid <= 1'b1;
          bad_first   = 1'b0;
          sts_delay   = 88 + ($random(seed) & 7);   // real status lands after next block is queued
        end else begin
          o_sts       <= {`AD_WR_EOF_TAG, 1'b1, 1'b1};
          o_sts_valid <= 1'b1;
          sts_armed   = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_ad9434_capture.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ad9434_params.svh"

module tb_ad9434_capture;

  import ad9434_pkg::*;

  localparam logic [31:0] SEED = 32'h5d3a_8de9;
  localparam int NUM_CAPTURES  = 6;
  localparam int LOG_DEPTH     = 65536;
  localparam int TRIG_TIMEOUT  = 20;      // cycles until trigger is logged
  localparam int DRAIN_TIMEOUT = 20000;   // cycles for a whole capture to drain
  localparam int BLK_SAMPLES   = `AD_SAMPLES_PER_WORD * `AD_WORDS_PER_BLOCK;

  logic       adc_clk;
  logic       rst;
  logic       i_trig;
  logic [9:0] i_us_capture;
  adc_ddr_t   i_adc;
  logic       o_cap_done;
  logic       o_overflow;
  s2mm_cmd_t  o_cmd;
  logic       o_cmd_valid;
  logic       i_cmd_ready;
  s2mm_data_t o_wr;
  logic       o_wr_valid;
  logic       i_wr_ready;
  s2mm_sts_t  i_sts;
  logic       i_sts_valid;

  integer   seed;
  int       edge_cnt = 0;              // rising edges since time 0
  adc_ddr_t adc_log [LOG_DEPTH];       // i_adc as seen on each edge
  int       trig_edges[$];             // edge where i_trig is first seen high
  int       done_edges[$];             // edges sampling o_cap_done high
  logic     trig_prev = 1'b0;
  logic     done_prev = 1'b0;
  int       cmd_seen = 0;              // command transfers so far
  int       good_sts = 0;              // matching status beats so far

  ad9434_capture_top uut (
    .adc_clk(adc_clk), .rst(rst), .i_trig(i_trig), .i_us_capture(i_us_capture),
    .i_adc(i_adc), .o_cap_done(o_cap_done), .o_overflow(o_overflow),
    .o_cmd(o_cmd), .o_cmd_valid(o_cmd_valid), .i_cmd_ready(i_cmd_ready),
    .o_wr(o_wr), .o_wr_valid(o_wr_valid), .i_wr_ready(i_wr_ready),
    .i_sts(i_sts), .i_sts_valid(i_sts_valid)
  );

  s2mm_responder #(.SEED(SEED)) u_resp (
    .adc_clk(adc_clk), .rst(rst), .i_cmd(o_cmd), .i_cmd_valid(o_cmd_valid),
    .o_cmd_ready(i_cmd_ready), .i_wr(o_wr), .i_wr_valid(o_wr_valid),
    .o_wr_ready(i_wr_ready), .o_sts(i_sts), .o_sts_valid(i_sts_valid)
  );

  initial begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;  // 25 MHz sim clock
  end

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  // log inputs, watch control outputs and the cmd/status ordering, drive new adc data
  always @(posedge adc_clk) begin
    if (!rst) begin
      assert (edge_cnt < LOG_DEPTH) else fail_stop("sample log overrun, run took too long");
      adc_log[edge_cnt] = i_adc;               // value the dut takes on this edge
      if (i_trig && !trig_prev) begin
        trig_edges.push_back(edge_cnt);
      end
      assert (!(o_cap_done && done_prev)) else fail_stop("o_cap_done stayed high two cycles");
      if (o_cap_done) begin
        done_edges.push_back(edge_cnt);
      end
      assert (!o_overflow)
        else fail_stop($sformatf("error: o_overflow got %h exp %h", o_overflow, 1'b0));
      if (o_cmd_valid) begin
        assert (cmd_seen == good_sts) else fail_stop("command raised before its status came back");
        if (i_cmd_ready) begin
          cmd_seen++;
        end
      end
      if (i_sts_valid && i_sts.tkeep && i_sts.tlast && (i_sts.tdata == `AD_WR_EOF_TAG)) begin
        good_sts++;
      end
    end
    trig_prev = i_trig;
    done_prev = o_cap_done;
    edge_cnt++;
    i_adc <= adc_ddr_t'($random(seed));
  end

  task automatic run_capture(input int n);
    int          data_base;
    int          cmd_base;
    int          sts_base;
    int          done_base;
    int          trig_base;
    int          wait_cnt;
    int          t0;
    int          n_smp;
    int          n_blk;
    int          n_words;
    int          k;
    logic [15:0] smp;
    logic [63:0] exp_word;
    logic        exp_last;
    adc_ddr_t    a;
    s2mm_data_t  beat;
    s2mm_cmd_t   cmd;
    s2mm_cmd_t   exp_cmd;
    data_base = u_resp.data_q.size();
    cmd_base  = u_resp.cmd_q.size();
    sts_base  = good_sts;
    done_base = done_edges.size();
    trig_base = trig_edges.size();
    n_smp     = n * `AD_CYCLES_PER_US;
    n_blk     = (n_smp + BLK_SAMPLES - 1) / BLK_SAMPLES;  // partial block padded
    n_words   = n_blk * `AD_WORDS_PER_BLOCK;
    @(posedge adc_clk);
    i_us_capture <= 10'(n);
    i_trig       <= 1'b1;
    wait_cnt = 0;
    while (trig_edges.size() == trig_base) begin
      @(posedge adc_clk);
      wait_cnt++;
      if (wait_cnt > TRIG_TIMEOUT) fail_stop("timeout, trigger never seen on the input");
    end
    repeat (2) @(posedge adc_clk);
    i_trig <= 1'b0;
    wait_cnt = 0;
    while ((u_resp.data_q.size() < data_base + n_words) || (good_sts < sts_base + n_blk) ||
           (done_edges.size() == done_base)) begin
      @(posedge adc_clk);
      wait_cnt++;
      if (wait_cnt > DRAIN_TIMEOUT) fail_stop("timeout, capture did not drain to memory");
    end
    repeat (40) @(posedge adc_clk);  // stray extra beats would land here
    assert (u_resp.data_q.size() == data_base + n_words)
      else fail_stop($sformatf("error: o_wr beat count got %h exp %h",
                               u_resp.data_q.size() - data_base, n_words));
    assert (u_resp.cmd_q.size() == cmd_base + n_blk)
      else fail_stop($sformatf("error: o_cmd count got %h exp %h",
                               u_resp.cmd_q.size() - cmd_base, n_blk));
    assert (done_edges.size() == done_base + 1)
      else fail_stop($sformatf("error: o_cap_done pulses got %h exp %h",
                               done_edges.size() - done_base, 1));
    t0 = trig_edges[trig_base] + 3;  // sample 0 edge
    assert (done_edges[done_base] == t0 + n_smp + 2)
      else fail_stop($sformatf("error: o_cap_done edge got %h exp %h",
                               done_edges[done_base], t0 + n_smp + 2));
    for (int b = 0; b < n_blk; b++) begin
      cmd           = u_resp.cmd_q[cmd_base + b];
      exp_cmd       = '0;
      exp_cmd.tag   = `AD_WR_EOF_TAG;
      exp_cmd.saddr = `AD_DDR_BASE_ADDR + 32'(b * `AD_BLOCK_BYTES);  // restarts per trigger
      exp_cmd.eof   = 1'b1;
      exp_cmd.incr  = 1'b1;
      exp_cmd.btt   = 23'(`AD_BLOCK_BYTES);
      assert (cmd == exp_cmd)
        else fail_stop($sformatf("error: o_cmd block %0d got %h exp %h", b, cmd, exp_cmd));
    end
    for (int w = 0; w < n_words; w++) begin
      exp_word = '0;
      for (int j = 0; j < `AD_SAMPLES_PER_WORD; j++) begin
        k = w * `AD_SAMPLES_PER_WORD + j;
        a = adc_log[t0 + k];
        smp = (k < n_smp) ? {4'b0000, a.rise, a.fall} : 16'h0000;  // zero pad
        exp_word[16*j +: 16] = smp;
      end
      exp_last = ((w % `AD_WORDS_PER_BLOCK) == `AD_WORDS_PER_BLOCK - 1);  // every 32nd beat
      beat = u_resp.data_q[data_base + w];
      assert (beat.tdata == exp_word)
        else fail_stop($sformatf("error: o_wr.tdata beat %0d got %h exp %h", w, beat.tdata,
                                 exp_word));
      assert (beat.tkeep == 8'hff)
        else fail_stop($sformatf("error: o_wr.tkeep beat %0d got %h exp %h", w, beat.tkeep,
                                 8'hff));
      assert (beat.tlast == exp_last)
        else fail_stop($sformatf("error: o_wr.tlast beat %0d got %h exp %h", w, beat.tlast,
                                 exp_last));
    end
  endtask

  initial begin
    int n_list [NUM_CAPTURES];
    seed         = SEED;
    rst          = 1'b1;
    i_trig       = 1'b0;
    i_us_capture = '0;
    i_adc        = '0;
    for (int c = 0; c < NUM_CAPTURES; c++) begin
      n_list[c] = 1 + ($random(seed) & 7);  // 1..8 us
    end
    repeat (4) @(posedge adc_clk);
    rst <= 1'b0;
    @(posedge adc_clk);
    assert (o_cmd_valid == 1'b0)
      else fail_stop($sformatf("error: o_cmd_valid got %h exp %h", o_cmd_valid, 1'b0));
    assert (o_wr_valid == 1'b0)
      else fail_stop($sformatf("error: o_wr_valid got %h exp %h", o_wr_valid, 1'b0));
    for (int c = 0; c < NUM_CAPTURES; c++) begin
      run_capture(n_list[c]);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
src/ad9434_pkg.sv
src/capture_ctrl.sv
src/sample_packer.sv
src/sample_fifo.sv
src/s2mm_burst_writer.sv
src/ad9434_capture_top.sv
verification/s2mm_responder.sv
verification/tb_ad9434_capture.sv
